/* hw/hamming74_decoder.sv */
// Hamming(7,4) decoder with single-bit correction
// Purely combinational; codeword bit 0 holds position 1
`timescale 1ns/10ps

module hamming74_decoder (
    input  logic [6:0]                 codeword,
    output uart_link_pkg::ham_result_t result
);

    logic [2:0] syndrome;   // Position of the bad bit, 0 if clean
    logic [6:0] fixed;

    // Parity checks over positions with the matching index bit set
    assign syndrome[0] = codeword[0] ^ codeword[2] ^ codeword[4] ^ codeword[6];  // 1 3 5 7
    assign syndrome[1] = codeword[1] ^ codeword[2] ^ codeword[5] ^ codeword[6];  // 2 3 6 7
    assign syndrome[2] = codeword[3] ^ codeword[4] ^ codeword[5] ^ codeword[6];  // 4 5 6 7

    always_comb begin
        fixed = codeword;
        if (syndrome != 3'd0) begin
            fixed[syndrome - 3'd1] = ~codeword[syndrome - 3'd1];   // Flip named bit
        end
    end

    // Data bits sit at positions 3, 5, 6, 7
    assign result.nibble    = {fixed[6], fixed[5], fixed[4], fixed[2]};
    assign result.corrected = (syndrome != 3'd0);

endmodule

/* hw/link_controller.sv */
// Link controller with startup delay, status byte, command and codeword
// replies, LED state and a one-entry reply buffer toward the transmitter
// Replies start two cycles after rx_done when the transmitter is idle
`timescale 1ns/10ps

module link_controller (
    input  logic                       clk,
    input  logic                       rst_n,
    input  uart_link_pkg::rx_result_t  rx_result,
    input  logic                       rx_done,
    input  logic                       tx_busy,
    output logic [7:0]                 tx_data,
    output logic                       tx_start,
    output uart_link_pkg::led_t        led
);

    logic [$clog2(uart_link_pkg::STARTUP_CYCLES)-1:0] start_cnt;
    logic        started;       // Status byte issued
    logic        startup_done;  // Last startup cycle
    logic        buf_full;
    logic [7:0]  buf_data;
    logic        accept;        // Take this byte into the buffer
    logic        issue;         // Hand buffered reply to the transmitter
    logic        is_on;
    logic        is_off;
    logic        is_toggle;
    logic [7:0]  reply;
    uart_link_pkg::ham_result_t ham;

    hamming74_decoder u_hamming (
        .codeword (rx_result.data.frame.codeword),
        .result   (ham)
    );

    assign startup_done = !started && (start_cnt == uart_link_pkg::STARTUP_CYCLES - 1);
    assign accept       = rx_done && started && !buf_full;   // Drop if buffer still full
    assign issue        = buf_full && !tx_busy;

    // Same byte checked as raw command code
    assign is_on     = (rx_result.data.raw == uart_link_pkg::CMD_LED_ON);
    assign is_off    = (rx_result.data.raw == uart_link_pkg::CMD_LED_OFF);
    assign is_toggle = (rx_result.data.raw == uart_link_pkg::CMD_LED_TOGGLE);

    always_comb begin
        if (rx_result.parity_error) begin
            reply = uart_link_pkg::BYTE_NAK;
        end else if (is_on || is_off || is_toggle) begin
            reply = uart_link_pkg::BYTE_ACK;
        end else begin
            reply = {3'b000, ham.corrected, ham.nibble};   // Decoded codeword reply
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_cnt <= '0;
            started   <= 1'b0;
            tx_start  <= 1'b0;
            buf_full  <= 1'b0;
            led       <= '1;    // All LEDs off
        end else begin
            tx_start <= 1'b0;
            if (!started) begin
                start_cnt <= start_cnt + 1'b1;
                if (startup_done) begin
                    started   <= 1'b1;
                    tx_start  <= 1'b1;       // Status byte
                    led.green <= 1'b0;       // Link running
                end
            end else if (issue) begin
                tx_start <= 1'b1;
                buf_full <= 1'b0;
            end

            if (accept) begin
                buf_full <= 1'b1;
                if (rx_result.parity_error) begin
                    led.red <= 1'b0;         // Sticky until reset
                end else if (is_on) begin
                    led.blue <= 1'b0;
                end else if (is_off) begin
                    led.blue <= 1'b1;
                end else if (is_toggle) begin
                    led.blue <= ~led.blue;
                end
            end
        end
    end

    // Reply bytes
    always_ff @(posedge clk) begin
        if (startup_done) begin
            tx_data <= uart_link_pkg::BYTE_STATUS;
        end else if (issue) begin
            tx_data <= buf_data;
        end
        if (accept) begin
            buf_data <= reply;
        end
    end

endmodule

/* hw/uart_link_pkg.sv */
// Shared constants and types for the UART command link
// Serial timing, startup delay, command and reply codes, and the
// structs passed between receiver, controller and transmitter
package uart_link_pkg;

    // Serial and startup timing
    localparam int CLKS_PER_BIT   = 16;   // Clock cycles per serial bit
    localparam int STARTUP_CYCLES = 64;   // Delay before the status byte

    // Status byte sent once after startup
    localparam logic [7:0] BYTE_STATUS = 8'h00;

    // Command codes, matched on the full byte
    localparam logic [7:0] CMD_LED_ON     = 8'h33;
    localparam logic [7:0] CMD_LED_OFF    = 8'h66;
    localparam logic [7:0] CMD_LED_TOGGLE = 8'h9D;

    // Reply codes
    localparam logic [7:0] BYTE_ACK = 8'h3C;
    localparam logic [7:0] BYTE_NAK = 8'hC3;  // Parity error reply

    // Hamming(7,4) frame in a received byte
    // Codeword bit 0..6 is position 1..7: p1 p2 d1 p3 d2 d3 d4
    typedef struct packed {
        logic       spare;      // Top bit, ignored
        logic [6:0] codeword;
    } hamm_frame_t;

    // One received byte, read both as command and as codeword
    typedef union packed {
        logic [7:0]  raw;
        hamm_frame_t frame;
    } rx_word_u;

    // Receiver output, valid with the done strobe
    typedef struct packed {
        rx_word_u data;
        logic     parity_error;   // Even parity mismatch
    } rx_result_t;

    // Decoder output
    typedef struct packed {
        logic [3:0] nibble;     // d4..d1, d1 in bit 0
        logic       corrected;  // A bit was flipped
    } ham_result_t;

    // Board LEDs, all active low
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } led_t;

endpackage

/* hw/uart_link_top.sv */
// Top level of the UART command link
// Receiver feeds the controller, the controller drives the transmitter
`timescale 1ns/10ps

module uart_link_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rx,
    output logic                tx,
    output uart_link_pkg::led_t led
);

    uart_link_pkg::rx_result_t rx_result;
    logic       rx_done;    // One-cycle strobe
    logic [7:0] tx_data;
    logic       tx_start;   // One-cycle strobe
    logic       tx_busy;

    uart_rx u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .rx_result (rx_result),
        .rx_done   (rx_done)
    );

    link_controller u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_result (rx_result),
        .rx_done   (rx_done),
        .tx_busy   (tx_busy),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .led       (led)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

/* hw/uart_rx.sv */
// UART receiver, 8 data bits, even parity, one stop bit
// Samples each bit in the middle of its bit time and gives a one-cycle
// done strobe at mid stop bit, with the byte and a parity error flag
`timescale 1ns/10ps

module uart_rx (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rx,
    output uart_link_pkg::rx_result_t  rx_result,
    output logic                       rx_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } state_t;

    state_t state;

    logic [1:0] rx_sync;        // Two-flop synchronizer
    logic       rx_s;           // Synchronized line
    logic       rx_prev;        // Previous value, for edge detect
    logic [$clog2(uart_link_pkg::CLKS_PER_BIT)-1:0] bit_cnt;
    logic [2:0] bit_idx;        // Data bit index
    logic       bit_end;        // Last cycle of a bit time
    logic       half_end;       // Middle of start bit
    logic [7:0] shift_reg;
    logic       parity_bit;

    assign rx_s     = rx_sync[1];
    assign bit_end  = (bit_cnt == uart_link_pkg::CLKS_PER_BIT - 1);
    assign half_end = (bit_cnt == uart_link_pkg::CLKS_PER_BIT / 2 - 1);

    // Control path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;   // Line idles high
            rx_prev <= 1'b1;
            state   <= S_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_prev <= rx_s;
            rx_done <= 1'b0;    // Strobe by default low

            case (state)
                S_IDLE: begin
                    bit_cnt <= '0;
                    if (rx_prev && !rx_s) begin   // Falling edge, maybe a start bit
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (half_end) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch if line went back high
                        state   <= rx_s ? S_IDLE : S_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_PARITY;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_PARITY: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        state   <= S_STOP;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_STOP: begin
                    if (bit_end) begin   // Mid stop bit
                        rx_done <= 1'b1;
                        state   <= S_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Data path, LSB first into the top of the shifter
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_end) begin
            shift_reg <= {rx_s, shift_reg[7:1]};
        end
        if (state == S_PARITY && bit_end) begin
            parity_bit <= rx_s;
        end
        if (state == S_STOP && bit_end) begin   // Held until next strobe
            rx_result.data.raw     <= shift_reg;
            rx_result.parity_error <= parity_bit ^ (^shift_reg);
        end
    end

endmodule

/* hw/uart_tx.sv */
// UART transmitter, 8 data bits, even parity, one stop bit
// A one-cycle start strobe loads the byte; busy stays high from the
// next cycle through the end of the stop bit
`timescale 1ns/10ps

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy
);

    logic [$clog2(uart_link_pkg::CLKS_PER_BIT)-1:0] clk_cnt;
    logic [3:0] bit_idx;       // 0 start, 1..8 data, 9 parity, 10 stop
    logic [9:0] shift_reg;     // Bits still to send after the start bit
    logic       load;
    logic       bit_end;

    assign load    = tx_start && !tx_busy;
    assign bit_end = (clk_cnt == uart_link_pkg::CLKS_PER_BIT - 1);

    // Line and bit timing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx      <= 1'b1;    // Idle high
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            if (load) begin
                tx      <= 1'b0;            // Start bit next cycle
                tx_busy <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd10) begin     // End of stop bit
                tx_busy <= 1'b0;
                tx      <= 1'b1;
            end else begin
                tx      <= shift_reg[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Frame shifter
    // Stop, parity and data are loaded together
    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= {1'b1, ^tx_data, tx_data};   // Even parity over the byte
        end else if (tx_busy && bit_end) begin
            shift_reg <= {1'b1, shift_reg[9:1]};
        end
    end

endmodule

/* list.f */
hw/uart_link_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/hamming74_decoder.sv
hw/link_controller.sv
hw/uart_link_top.sv
sim/uart_link_checker.sv
sim/tb_clock_gen.sv
sim/tb_uart_link.sv

/* sim/tb_clock_gen.sv */
// Testbench clock and reset source
// 8 ns clock, synchronous active-low reset held for two rising edges
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;          // Released just after the second edge
    end

endmodule

/* sim/tb_uart_link.sv */
// Testbench for the UART command link
// Drives serial frames on rx, decodes replies on tx and checks LED state
`timescale 1ns/10ps

module tb_uart_link;

    localparam int BIT_CLKS       = uart_link_pkg::CLKS_PER_BIT;
    localparam int HAMMING_COUNT  = 20;
    localparam int TIMEOUT_CYCLES = 20000;  // Startup + ~40 exchanges of 2 x 176 cycles

    logic                clk;
    logic                rst_n;
    logic                rx;
    logic                tx;
    uart_link_pkg::led_t led;

    int         seed = 41;
    int         cycle_count = 0;
    int         n;
    logic       red_on;       // Expected LED state, active high
    logic       blue_on;
    logic [7:0] got;
    logic [7:0] word;
    logic [3:0] nibble;
    logic       flipped;

    tb_clock_gen u_clock (.clk(clk), .rst_n(rst_n));

    uart_link_top DUT (.clk(clk), .rst_n(rst_n), .rx(rx), .tx(tx), .led(led));

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        $display("[FAIL] %s expected 0x%h got 0x%h", name, expected, actual);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // Positions 1..7 in bits 0..6: p1 p2 d1 p3 d2 d3 d4
    function automatic logic [6:0] hamming_encode(input logic [3:0] d);
        logic p1;
        logic p2;
        logic p3;
        p1 = d[0] ^ d[1] ^ d[3];
        p2 = d[0] ^ d[2] ^ d[3];
        p3 = d[1] ^ d[2] ^ d[3];
        return {d[3], d[2], d[1], p3, d[0], p2, p1};
    endfunction

    function automatic logic is_command(input logic [7:0] b);
        return (b == 8'h33) || (b == 8'h66) || (b == 8'h9D);
    endfunction

    // One frame on rx, bits change 1 ns after the clock edge
    task automatic send_byte(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        int          i;
        frame = {1'b1, (^data) ^ bad_parity, data, 1'b0};   // Stop, parity, data, start
        for (i = 0; i < 11; i++) begin
            @(posedge clk);
            #1 rx = frame[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    // Sampled on the falling clock edge, near mid-bit
    task automatic receive_byte(output logic [7:0] data);
        int i;
        @(negedge clk);
        while (tx !== 1'b0) @(negedge clk);
        repeat (BIT_CLKS / 2) @(negedge clk);
        assert (tx === 1'b0) else stop_with_failure("start bit on tx was too short");
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            data[i] = tx;
        end
        repeat (BIT_CLKS) @(negedge clk);
        assert (tx === ^data) else show_mismatch("tx parity", {7'b0, ^data}, {7'b0, tx});
        repeat (BIT_CLKS) @(negedge clk);
        assert (tx === 1'b1) else stop_with_failure("stop bit on tx was not high");
    endtask

    task automatic exchange(input logic [7:0] data, input logic bad_parity,
                            input logic [7:0] expected);
        logic [7:0] reply;
        fork
            send_byte(data, bad_parity);
            receive_byte(reply);
        join
        assert (reply === expected) else show_mismatch("tx reply", expected, reply);
    endtask

    task automatic check_leds();
        logic [2:0] expected;
        expected = {~red_on, 1'b0, ~blue_on};   // Green on once running
        assert (led === expected) else show_mismatch("led", {5'b0, expected}, {5'b0, led});
    endtask

    // Random nibble, spare bit and optional single-bit error
    task automatic draw_codeword(output logic [7:0] w, output logic [3:0] d,
                                 output logic flip);
        logic [31:0] r;
        logic [6:0]  cw;
        int          pos;
        do begin
            r    = $random(seed);
            d    = r[3:0];
            flip = r[4];
            pos  = r[31:8] % 7;
            cw   = hamming_encode(d);
            if (flip) begin
                cw[pos] = ~cw[pos];
            end
            w = {r[5], cw};
        end while (is_command(w));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            stop_with_failure("Timeout: the link stopped answering");
        end
    end

    always @(negedge clk) begin
        if (DUT.u_checker.fail_count != 0) begin
            stop_with_failure("A line or strobe rule in the checker was broken");
        end
    end

    initial begin
        rx      = 1'b1;   // Idle line
        red_on  = 1'b0;
        blue_on = 1'b0;
        wait (rst_n === 1'b1);

        // Quiet line and dark LEDs during startup
        repeat (uart_link_pkg::STARTUP_CYCLES - 4) @(negedge clk);
        assert (tx === 1'b1) else stop_with_failure("tx left idle during the startup delay");
        assert (led === 3'b111) else show_mismatch("led", 8'h07, {5'b0, led});
        receive_byte(got);
        assert (got === 8'h00) else show_mismatch("status byte", 8'h00, got);
        check_leds();

        // Blue follows on, off, on, off
        exchange(8'h33, 1'b0, 8'h3C);
        blue_on = 1'b1;
        check_leds();
        exchange(8'h9D, 1'b0, 8'h3C);
        blue_on = 1'b0;
        check_leds();
        exchange(8'h9D, 1'b0, 8'h3C);
        blue_on = 1'b1;
        check_leds();
        exchange(8'h66, 1'b0, 8'h3C);
        blue_on = 1'b0;
        check_leds();

        // Codewords, reply is {000, corrected, nibble}
        for (n = 0; n < HAMMING_COUNT; n++) begin
            draw_codeword(word, nibble, flipped);
            exchange(word, 1'b0, {3'b000, flipped, nibble});
            check_leds();
        end

        // Bad parity on a command byte, blue must not move
        exchange(8'h33, 1'b1, 8'hC3);
        red_on = 1'b1;
        check_leds();
        exchange(8'h9D, 1'b0, 8'h3C);
        blue_on = 1'b1;
        check_leds();

        repeat (BIT_CLKS) @(negedge clk);
        if (DUT.u_checker.fail_count != 0) begin
            $display("Result: FAILED");
            $fatal(1);
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* sim/uart_link_checker.sv */
// Concurrent assertions on the serial line, strobes and LEDs of the link
// Bound into the top level; fail_count lets the testbench see failures
`timescale 1ns/10ps

module uart_link_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                rx_done,
    input logic                tx_start,
    input logic                tx_busy,
    input logic                tx,
    input uart_link_pkg::led_t led
);

    int unsigned fail_count = 0;   // Bumped by every failing assertion
    logic        seen_start;       // First tx_start has happened

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen_start <= 1'b0;
        end else if (tx_start) begin
            seen_start <= 1'b1;
        end
    end

    // Line idles high whenever the transmitter is free
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
        else begin
            fail_count++;
            $error("tx low while the transmitter is idle");
        end

    // Single-cycle strobes
    rx_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_done |=> !rx_done)
        else begin
            fail_count++;
            $error("rx_done high for more than one cycle");
        end

    tx_start_pulse: assert property (@(posedge clk) disable iff (!rst_n) tx_start |=> !tx_start)
        else begin
            fail_count++;
            $error("tx_start high for more than one cycle");
        end

    // Start only into an idle transmitter
    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
        else begin
            fail_count++;
            $error("tx_start while tx_busy is high");
        end

    // Green lights in the same edge as the status strobe
    leds_dark_at_startup: assert property (@(posedge clk) disable iff (!rst_n)
            (!seen_start && !tx_start) |-> (led == 3'b111))
        else begin
            fail_count++;
            $error("led changed before the status byte was started");
        end

endmodule

bind uart_link_top uart_link_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_done  (rx_done),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx       (tx),
    .led      (led)
);
